/* Makefile */
TOP = tb_decode_issue
LOG = sim.log

.PHONY: run build lint clean

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
rtl/decode_issue_pkg.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/rename_table.sv
rtl/phys_regfile.sv
rtl/inst_router.sv
rtl/decode_issue_unit.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_decode_issue.sv

/* rtl/decode_issue_pkg.sv */
/*
  Sizes, opcodes and shared types of the decode and issue stage
  Micro-op, immediate and jump enums, instruction word union,
  fetch, issue, completion and squash packets
*/
`default_nettype none

package decode_issue_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_PHYS_REGS = 36;
  localparam int PREG_BITS     = 6;
  localparam int SEQ_BITS      = 8;
  localparam int NUM_PIPES     = 2;
  localparam int PIPE_ALU      = 0;
  localparam int PIPE_MEM      = 1;
  // Free list only ever holds the pregs beyond the architectural set
  localparam int FREE_DEPTH    = NUM_PHYS_REGS - NUM_ARCH_REGS;
  localparam int FREE_PTR_BITS = 2;

  // ------------------------------
  // Encodings
  // ------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [6:0] F7_ADD     = 7'b0000000;
  localparam logic [6:0] F7_MUL     = 7'b0000001;

  typedef enum logic [2:0] {
    UOP_ADD, UOP_ADDI, UOP_MUL, UOP_LW, UOP_SW, UOP_JAL, UOP_JALR, UOP_INV
  } uop_e;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_J} imm_kind_e;

  typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR} jump_kind_e;

  // ------------------------------
  // Instruction word views
  // ------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_form_t;

  // Immediate-carrying view with fields named after the bits they may hold
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2_or_imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd_or_imm;
    logic [6:0] opcode;
  } is_form_t;

  typedef union packed {
    r_form_t  rform;
    is_form_t isform;
  } inst_word_u;

  // ------------------------------
  // Packets
  // ------------------------------
  typedef struct packed {
    inst_word_u          inst;
    logic [31:0]         pc;
    logic [SEQ_BITS-1:0] seq;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0]          pc;
    logic [31:0]          op1;
    logic [31:0]          op2;
    uop_e                 uop;
    logic [4:0]           waddr;
    logic [SEQ_BITS-1:0]  seq;
    logic [PREG_BITS-1:0] preg;
    logic [PREG_BITS-1:0] ppreg;
    logic [31:0]          mem_data;
  } issue_pkt_t;

  typedef struct packed {
    logic                 val;
    logic                 wen;
    logic [PREG_BITS-1:0] preg;
    logic [PREG_BITS-1:0] ppreg;
    logic [31:0]          wdata;
    logic [SEQ_BITS-1:0]  seq;
  } complete_t;

  typedef struct packed {
    logic                val;
    logic [31:0]         target;
    logic [SEQ_BITS-1:0] seq;
  } squash_t;

endpackage

`default_nettype wire

/* rtl/decode_issue_unit.sv */
/*
  Decode and issue stage, top level
  Fetch register, stall logic, operand muxing, squash pulse,
  decoder, immediate, rename, register file and router instances
*/
`timescale 1ns/10ps
`default_nettype none

module decode_issue_unit (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   fetch_val,
  input  decode_issue_pkg::fetch_pkt_t           fetch_pkt,
  output logic                                   fetch_rdy,
  output logic [decode_issue_pkg::NUM_PIPES-1:0] ex_val,
  input  logic [decode_issue_pkg::NUM_PIPES-1:0] ex_rdy,
  output decode_issue_pkg::issue_pkt_t           ex_pkt,
  input  decode_issue_pkg::complete_t            complete,
  output decode_issue_pkg::squash_t              squash
);
  import decode_issue_pkg::*;

  logic                 f_val_q;
  fetch_pkt_t           f_pkt_q;
  logic                 fetch_xfer;
  logic                 issue_xfer;

  logic                 dec_val;
  uop_e                 dec_uop;
  logic [4:0]           dec_rs1;
  logic [4:0]           dec_rs2;
  logic [4:0]           dec_rd;
  logic                 dec_wen;
  imm_kind_e            dec_imm_kind;
  logic                 dec_op2_imm;
  jump_kind_e           dec_jump;
  logic [31:0]          imm;

  logic [1:0][PREG_BITS-1:0] src_preg;
  logic [1:0]           src_pending;
  logic                 alloc_rdy;
  logic                 alloc_en;
  logic [PREG_BITS-1:0] alloc_preg;
  logic [PREG_BITS-1:0] alloc_ppreg;
  logic [1:0][31:0]     rdata;

  logic                 stall;
  logic                 route_val;
  logic [31:0]          jump_target;

  // ------------------------------
  // Fetch register
  // ------------------------------
  assign fetch_xfer = fetch_val & fetch_rdy;
  // Accept when empty or when the held instruction leaves this cycle
  assign fetch_rdy  = !f_val_q | issue_xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      f_val_q <= 1'b0;
    end else if (fetch_xfer) begin
      f_val_q <= 1'b1;
    end else if (issue_xfer) begin
      f_val_q <= 1'b0;
    end
  end

  // Held instruction payload
  always_ff @(posedge clk) begin
    if (fetch_xfer) f_pkt_q <= fetch_pkt;
  end

  // ------------------------------
  // Decode and rename
  // ------------------------------
  inst_decoder u_decoder (
    .inst     (f_pkt_q.inst),
    .dec_val  (dec_val),
    .uop      (dec_uop),
    .rs1      (dec_rs1),
    .rs2      (dec_rs2),
    .rd       (dec_rd),
    .wen      (dec_wen),
    .imm_kind (dec_imm_kind),
    .op2_imm  (dec_op2_imm),
    .jump     (dec_jump)
  );

  imm_gen u_imm_gen (
    .inst     (f_pkt_q.inst),
    .imm_kind (dec_imm_kind),
    .imm      (imm)
  );

  // Allocate only on the issue transfer of a writer
  assign alloc_en = issue_xfer & dec_wen;

  rename_table u_rename (
    .clk         (clk),
    .rst         (rst),
    .src_areg    ({dec_rs2, dec_rs1}),
    .src_preg    (src_preg),
    .src_pending (src_pending),
    .alloc_areg  (dec_rd),
    .alloc_en    (alloc_en),
    .alloc_rdy   (alloc_rdy),
    .alloc_preg  (alloc_preg),
    .alloc_ppreg (alloc_ppreg),
    .complete    (complete)
  );

  phys_regfile u_regfile (
    .clk   (clk),
    .raddr (src_preg),
    .rdata (rdata),
    .waddr (complete.preg),
    .wdata (complete.wdata),
    .wen   (complete.val & complete.wen)
  );

  // ------------------------------
  // Stall and routing
  // ------------------------------
  // Pipe readiness is folded in by the router
  assign stall     = (|src_pending) | (dec_wen & !alloc_rdy);
  // Unknown words never issue and stay in the register
  assign route_val = f_val_q & dec_val & !stall;

  inst_router u_router (
    .uop    (dec_uop),
    .val    (route_val),
    .ex_rdy (ex_rdy),
    .ex_val (ex_val),
    .xfer   (issue_xfer)
  );

  // ------------------------------
  // Issue packet
  // ------------------------------
  always_comb begin
    ex_pkt.pc       = f_pkt_q.pc;
    ex_pkt.op1      = rdata[0];
    ex_pkt.op2      = dec_op2_imm ? imm : rdata[1];
    ex_pkt.uop      = dec_uop;
    ex_pkt.waddr    = dec_rd;
    ex_pkt.seq      = f_pkt_q.seq;
    ex_pkt.preg     = alloc_preg;
    ex_pkt.ppreg    = alloc_ppreg;
    // Store data always comes from rs2
    ex_pkt.mem_data = rdata[1];
  end

  // ------------------------------
  // Squash
  // ------------------------------
  always_comb begin
    case (dec_jump)
      JUMP_JAL:  jump_target = f_pkt_q.pc + imm;
      JUMP_JALR: jump_target = (rdata[0] + imm) & 32'hffff_fffe;
      default:   jump_target = 32'd0;
    endcase
  end

  // One pulse per jump at its issue
  assign squash.val    = (dec_jump != JUMP_NONE) & issue_xfer;
  assign squash.target = jump_target;
  assign squash.seq    = f_pkt_q.seq;

  // A jump leaves on the ALU pipe in the cycle of its squash
  a_squash_on_issue: assert property (@(posedge clk) disable iff (rst)
    squash.val |-> (ex_val[PIPE_ALU] && !ex_val[PIPE_MEM] && ex_rdy[PIPE_ALU]));

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
/*
  Immediate generator for I, S, U and J forms
*/
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
  input  decode_issue_pkg::inst_word_u inst,
  input  decode_issue_pkg::imm_kind_e  imm_kind,
  output logic [31:0]                  imm
);
  import decode_issue_pkg::*;

  is_form_t f;

  assign f = inst.isform;

  always_comb begin
    case (imm_kind)
      // inst[31:20]
      IMM_I: imm = {{20{f.imm_hi[6]}}, f.imm_hi, f.rs2_or_imm};
      // inst[31:25] and inst[11:7]
      IMM_S: imm = {{20{f.imm_hi[6]}}, f.imm_hi, f.rd_or_imm};
      // Upper 20 bits over a zero low half
      IMM_U: imm = {f.imm_hi, f.rs2_or_imm, f.rs1, f.funct3, 12'b0};
      // Scrambled jump offset with bit 0 implied zero
      IMM_J: imm = {{12{f.imm_hi[6]}}, f.rs1, f.funct3, f.rs2_or_imm[0],
                    f.imm_hi[5:0], f.rs2_or_imm[4:1], 1'b0};
      default: imm = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
/*
  TinyRV1 instruction decoder
  Micro-op, register fields, write enable and operand controls
*/
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
  input  decode_issue_pkg::inst_word_u inst,
  output logic                         dec_val,
  output decode_issue_pkg::uop_e       uop,
  output logic [4:0]                   rs1,
  output logic [4:0]                   rs2,
  output logic [4:0]                   rd,
  output logic                         wen,
  output decode_issue_pkg::imm_kind_e  imm_kind,
  output logic                         op2_imm,
  output decode_issue_pkg::jump_kind_e jump
);
  import decode_issue_pkg::*;

  always_comb begin
    // Defaults describe an unknown word
    dec_val  = 1'b0;
    uop      = UOP_INV;
    rs1      = 5'd0;
    rs2      = 5'd0;
    rd       = 5'd0;
    wen      = 1'b0;
    imm_kind = IMM_I;
    op2_imm  = 1'b0;
    jump     = JUMP_NONE;

    case (inst.rform.opcode)
      OPC_OP: begin
        if (inst.rform.funct3 == F3_ADD) begin
          if (inst.rform.funct7 == F7_ADD) begin
            dec_val = 1'b1;
            uop     = UOP_ADD;
          end else if (inst.rform.funct7 == F7_MUL) begin
            dec_val = 1'b1;
            uop     = UOP_MUL;
          end
        end
        rs1 = inst.rform.rs1;
        rs2 = inst.rform.rs2;
        rd  = inst.rform.rd;
        wen = dec_val;
      end
      OPC_OP_IMM: begin
        dec_val = (inst.rform.funct3 == F3_ADD);
        uop     = dec_val ? UOP_ADDI : UOP_INV;
        rs1     = inst.rform.rs1;
        rd      = inst.rform.rd;
        wen     = dec_val;
        op2_imm = 1'b1;
      end
      OPC_LOAD: begin
        dec_val = (inst.rform.funct3 == F3_WORD);
        uop     = dec_val ? UOP_LW : UOP_INV;
        rs1     = inst.rform.rs1;
        rd      = inst.rform.rd;
        wen     = dec_val;
        op2_imm = 1'b1;
      end
      OPC_STORE: begin
        // rs2 carries the store data
        dec_val  = (inst.rform.funct3 == F3_WORD);
        uop      = dec_val ? UOP_SW : UOP_INV;
        rs1      = inst.rform.rs1;
        rs2      = inst.rform.rs2;
        imm_kind = IMM_S;
        op2_imm  = 1'b1;
      end
      OPC_JAL: begin
        dec_val  = 1'b1;
        uop      = UOP_JAL;
        rd       = inst.rform.rd;
        wen      = 1'b1;
        imm_kind = IMM_J;
        op2_imm  = 1'b1;
        jump     = JUMP_JAL;
      end
      OPC_JALR: begin
        dec_val = (inst.rform.funct3 == F3_ADD);
        uop     = dec_val ? UOP_JALR : UOP_INV;
        rs1     = inst.rform.rs1;
        rd      = inst.rform.rd;
        wen     = dec_val;
        op2_imm = 1'b1;
        jump    = dec_val ? JUMP_JALR : JUMP_NONE;
      end
      default: ;
    endcase

    // Writes to x0 are discarded
    if (rd == 5'd0) wen = 1'b0;
  end

endmodule

`default_nettype wire

/* rtl/inst_router.sv */
/*
  Pipe router, ALU pipe or memory pipe by micro-op
*/
`timescale 1ns/10ps
`default_nettype none

module inst_router (
  input  decode_issue_pkg::uop_e                 uop,
  input  logic                                   val,
  input  logic [decode_issue_pkg::NUM_PIPES-1:0] ex_rdy,
  output logic [decode_issue_pkg::NUM_PIPES-1:0] ex_val,
  output logic                                   xfer
);
  import decode_issue_pkg::*;

  logic [NUM_PIPES-1:0] pipe_sel;

  // One-hot pipe choice
  always_comb begin
    pipe_sel = '0;
    case (uop)
      UOP_LW, UOP_SW: pipe_sel[PIPE_MEM] = 1'b1;
      default:        pipe_sel[PIPE_ALU] = 1'b1;
    endcase
  end

  assign ex_val = val ? pipe_sel : '0;

  // Only the chosen pipe can accept
  assign xfer = |(ex_val & ex_rdy);

endmodule

`default_nettype wire

/* rtl/phys_regfile.sv */
/*
  Physical register file, 36 entries
  Two combinational read ports, one write port
*/
`timescale 1ns/10ps
`default_nettype none

module phys_regfile (
  input  logic                                        clk,
  input  logic [1:0][decode_issue_pkg::PREG_BITS-1:0] raddr,
  output logic [1:0][31:0]                            rdata,
  input  logic [decode_issue_pkg::PREG_BITS-1:0]      waddr,
  input  logic [31:0]                                 wdata,
  input  logic                                        wen
);
  import decode_issue_pkg::*;

  logic [31:0] regs_q [NUM_PHYS_REGS];

  always_ff @(posedge clk) begin
    if (wen) regs_q[waddr] <= wdata;
  end

  // Preg 0 backs x0 and reads as zero
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      rdata[k] = (raddr[k] == '0) ? 32'd0 : regs_q[raddr[k]];
    end
  end

  // x0 never gets renamed, so no completion can target preg 0
  a_no_preg0_write: assert property (@(posedge clk)
    wen |-> (waddr != '0));

endmodule

`default_nettype wire

/* rtl/rename_table.sv */
/*
  Rename table for the issue stage
  Architectural-to-physical map, per-preg pending bits, free-list FIFO
*/
`timescale 1ns/10ps
`default_nettype none

module rename_table (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [1:0][4:0]                              src_areg,
  output logic [1:0][decode_issue_pkg::PREG_BITS-1:0]  src_preg,
  output logic [1:0]                                   src_pending,
  input  logic [4:0]                                   alloc_areg,
  input  logic                                         alloc_en,
  output logic                                         alloc_rdy,
  output logic [decode_issue_pkg::PREG_BITS-1:0]       alloc_preg,
  output logic [decode_issue_pkg::PREG_BITS-1:0]       alloc_ppreg,
  input  decode_issue_pkg::complete_t                  complete
);
  import decode_issue_pkg::*;

  logic [PREG_BITS-1:0]     map_q [NUM_ARCH_REGS];
  logic [NUM_PHYS_REGS-1:0] pending_q;
  logic [PREG_BITS-1:0]     free_q [FREE_DEPTH];
  logic [FREE_PTR_BITS-1:0] head_q;
  logic [FREE_PTR_BITS-1:0] tail_q;
  logic [FREE_PTR_BITS:0]   count_q;
  logic                     free_push;

  // ------------------------------
  // Lookups
  // ------------------------------
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      // x0 is hardwired to preg 0
      if (src_areg[k] == 5'd0) begin
        src_preg[k]    = '0;
        src_pending[k] = 1'b0;
      end else begin
        src_preg[k]    = map_q[src_areg[k]];
        src_pending[k] = pending_q[src_preg[k]];
      end
    end
  end

  assign alloc_preg  = free_q[head_q];
  assign alloc_ppreg = map_q[alloc_areg];
  assign alloc_rdy   = (count_q != '0);

  // Stores complete without a register, so only writers free a preg
  assign free_push = complete.val & complete.wen;

  // ------------------------------
  // State update
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, spare pregs queued in ascending order
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_q[i] <= PREG_BITS'(i);
      end
      for (int i = 0; i < FREE_DEPTH; i++) begin
        free_q[i] <= PREG_BITS'(NUM_ARCH_REGS + i);
      end
      pending_q <= '0;
      head_q    <= '0;
      tail_q    <= '0;
      count_q   <= (FREE_PTR_BITS + 1)'(FREE_DEPTH);
    end else begin
      if (free_push) begin
        pending_q[complete.preg] <= 1'b0;
        free_q[tail_q]           <= complete.ppreg;
        tail_q                   <= tail_q + 1'b1;
      end
      if (alloc_en) begin
        map_q[alloc_areg]     <= alloc_preg;
        pending_q[alloc_preg] <= 1'b1;
        head_q                <= head_q + 1'b1;
      end
      count_q <= count_q + (FREE_PTR_BITS + 1)'(free_push)
                         - (FREE_PTR_BITS + 1)'(alloc_en);
    end
  end

  // Issue logic must stall a writer on an empty free list
  a_alloc_needs_rdy: assert property (@(posedge clk) disable iff (rst)
    alloc_en |-> alloc_rdy);

  // In-order freeing never returns more pregs than were handed out
  a_free_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (free_push && !alloc_en) |-> (count_q < FREE_DEPTH));

endmodule

`default_nettype wire

/* verification/decode_issue_cases.txt */
# inst pc wdata pipe op1 op2 preg ppreg squash target, all hex
# preg 00 marks an instruction without a destination register
00500093 00000100 00000005 0 00000000 00000005 20 01 0 00000000
00708113 00000104 0000000c 0 00000005 00000007 21 02 0 00000000
002081b3 00000108 00000011 0 00000005 0000000c 22 03 0 00000000
02218233 0000010c 000000cc 0 00000011 0000000c 23 04 0 00000000
0041a423 00000110 00000000 1 00000011 00000008 00 00 0 00000000
ffc0a283 00000114 00001234 1 00000005 fffffffc 01 05 0 00000000
0100036f 00000118 0000011c 0 00000000 00000010 02 06 1 00000128
003283e7 0000011c 00000120 0 00001234 00000003 03 07 1 00001236
00638433 00000120 0000023c 0 00000120 0000011c 04 08 0 00000000
fff08093 00000124 00000004 0 00000005 ffffffff 05 20 0 00000000
ff9ff06f 00000128 00000000 0 00000000 fffffff8 00 00 1 00000120
00102023 0000012c 00000000 1 00000000 00000000 00 00 0 00000000
021084b3 00000130 00000010 0 00000004 00000004 06 09 0 00000000
00208033 00000134 00000000 0 00000004 0000000c 00 00 0 00000000
0044a503 00000138 0000beef 1 00000010 00000004 07 0a 0 00000000

/* verification/tb_checker.sv */
/*
  Issue monitor and scoreboard
  Compares each issued packet, pipe and squash with the expected case,
  checks stability under back-pressure, prints one line per test
*/
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [decode_issue_pkg::NUM_PIPES-1:0] ex_val,
  input  logic [decode_issue_pkg::NUM_PIPES-1:0] ex_rdy,
  input  decode_issue_pkg::issue_pkt_t           ex_pkt,
  input  decode_issue_pkg::squash_t              squash,
  input  logic                                   fetch_rdy,
  input  logic                                   exp_valid,
  input  logic [7:0]                             exp_seq,
  input  logic [223:0]                           exp_rec,
  output int                                     tests_done,
  output int                                     tests_failed,
  output int                                     proto_errs
);
  import decode_issue_pkg::*;

  // Same layout as the case record of the testbench top
  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] wdata;
    logic [7:0]  pipe;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [7:0]  preg;
    logic [7:0]  ppreg;
    logic [7:0]  squash;
    logic [31:0] target;
  } case_t;

  case_t       exp;
  logic        xfer;
  logic        held;
  logic [1:0]  held_val;
  issue_pkt_t  held_pkt;
  // Architectural values as delivered by the completions, in program order
  logic [31:0] reg_model [32];

  assign exp  = case_t'(exp_rec);
  assign xfer = |(ex_val & ex_rdy);

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] want, inout int errs);
    if (got !== want) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, want);
      errs++;
    end
  endtask

  // Micro-op named by the opcode and funct fields of the word
  function automatic uop_e expected_uop(input logic [31:0] word);
    uop_e u;
    case (word[6:0])
      7'h33:   u = word[25] ? UOP_MUL : UOP_ADD;
      7'h13:   u = UOP_ADDI;
      7'h03:   u = UOP_LW;
      7'h23:   u = UOP_SW;
      7'h6f:   u = UOP_JAL;
      7'h67:   u = UOP_JALR;
      default: u = UOP_INV;
    endcase
    return u;
  endfunction

  initial begin
    tests_done   = 0;
    tests_failed = 0;
    proto_errs   = 0;
    held         = 1'b0;
    held_val     = '0;
    held_pkt     = '0;
  end

  always @(posedge clk) begin
    int errs;
    int pipe;
    errs = 0;
    pipe = ex_val[PIPE_MEM] ? 1 : 0;
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        reg_model[i] <= '0;
      end
    end else begin
      // ------------------------------
      // Back-pressure stability
      // ------------------------------
      if (held && ((ex_val !== held_val) || (ex_pkt !== held_pkt))) begin
        $display("Back-pressure: ex_val or ex_pkt changed before the issue at %0t ns", $time);
        proto_errs++;
      end
      if ((ex_val != '0) && !xfer && fetch_rdy) begin
        $display("Back-pressure: fetch_rdy high while an instruction waits at %0t ns", $time);
        proto_errs++;
      end
      held     <= (ex_val != '0) && !xfer;
      held_val <= ex_val;
      held_pkt <= ex_pkt;

      if (squash.val && !xfer) begin
        $display("Squash pulse without an issue at %0t ns", $time);
        proto_errs++;
      end

      // ------------------------------
      // Issue comparison
      // ------------------------------
      if (xfer && !exp_valid) begin
        $display("Issue at %0t ns with no instruction left to expect", $time);
        proto_errs++;
      end else if (xfer) begin
        // Exactly the expected pipe's valid bit
        check_word("ex_val", 32'(ex_val), 32'(1) << exp.pipe, errs);
        check_word("ex_pkt.uop", 32'(ex_pkt.uop), 32'(expected_uop(exp.inst)), errs);
        check_word("ex_pkt.pc", ex_pkt.pc, exp.pc, errs);
        check_word("ex_pkt.op1", ex_pkt.op1, exp.op1, errs);
        check_word("ex_pkt.op2", ex_pkt.op2, exp.op2, errs);
        check_word("ex_pkt.seq", 32'(ex_pkt.seq), 32'(exp_seq), errs);
        // Rename fields only mean something for writers
        if (exp.preg != 8'd0) begin
          check_word("ex_pkt.waddr", 32'(ex_pkt.waddr), 32'(exp.inst[11:7]), errs);
          check_word("ex_pkt.preg", 32'(ex_pkt.preg), 32'(exp.preg), errs);
          check_word("ex_pkt.ppreg", 32'(ex_pkt.ppreg), 32'(exp.ppreg), errs);
          reg_model[exp.inst[11:7]] <= exp.wdata;
        end
        // Stores are the memory-pipe instructions without a destination
        if (exp.pipe == 8'd1 && exp.preg == 8'd0) begin
          check_word("ex_pkt.mem_data", ex_pkt.mem_data, reg_model[exp.inst[24:20]], errs);
        end
        check_word("squash.val", 32'(squash.val), 32'(exp.squash[0]), errs);
        if (exp.squash[0]) begin
          check_word("squash.target", squash.target, exp.target, errs);
          check_word("squash.seq", 32'(squash.seq), 32'(exp_seq), errs);
        end
        tests_done++;
        if (errs != 0) tests_failed++;
        $display("Test %0d (inst %h, pipe %0d): %s", exp_seq, exp.inst, pipe,
                 (errs == 0) ? "ok" : "FAILED");
      end
    end
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
/*
  Testbench clock and reset source
  10 ns clock, synchronous reset held for 16 cycles
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    // Release on a rising edge so the DUT sees a clean first cycle
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

  always #5 clk = ~clk;

endmodule

`default_nettype wire

/* verification/tb_decode_issue.sv */
/*
  Testbench top for the decode and issue stage
  Reads the cases file, drives fetch, random pipe ready and in-order
  completions, instantiates the DUT, clock source and checker
*/
`timescale 1ns/10ps
`default_nettype none

module tb_decode_issue;
  import decode_issue_pkg::*;

  localparam int MAX_CASES = 64;
  localparam int TIMEOUT   = 200;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] wdata;
    logic [7:0]  pipe;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [7:0]  preg;
    logic [7:0]  ppreg;
    logic [7:0]  squash;
    logic [31:0] target;
  } case_t;

  logic       clk;
  logic       rst;
  logic       fetch_val;
  fetch_pkt_t fetch_pkt;
  logic       fetch_rdy;
  logic [1:0] ex_val;
  logic [1:0] ex_rdy;
  issue_pkt_t ex_pkt;
  complete_t  complete;
  squash_t    squash;

  case_t      cases [MAX_CASES];
  int         num_cases;
  int         issue_idx;
  int         cycle;
  int         seed;
  int         tests_done;
  int         tests_failed;
  int         proto_errs;
  complete_t  comp_q [$];
  int         due_q [$];

  tb_clock_gen u_clk (.clk(clk), .rst(rst));

  decode_issue_unit DUT (
    .clk       (clk),
    .rst       (rst),
    .fetch_val (fetch_val),
    .fetch_pkt (fetch_pkt),
    .fetch_rdy (fetch_rdy),
    .ex_val    (ex_val),
    .ex_rdy    (ex_rdy),
    .ex_pkt    (ex_pkt),
    .complete  (complete),
    .squash    (squash)
  );

  tb_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .ex_val       (ex_val),
    .ex_rdy       (ex_rdy),
    .ex_pkt       (ex_pkt),
    .squash       (squash),
    .fetch_rdy    (fetch_rdy),
    .exp_valid    (issue_idx < num_cases),
    .exp_seq      (8'(issue_idx)),
    .exp_rec      (cases[issue_idx % MAX_CASES]),
    .tests_done   (tests_done),
    .tests_failed (tests_failed),
    .proto_errs   (proto_errs)
  );

  // ------------------------------
  // Case file
  // ------------------------------
  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [10];
    fd = $fopen("verification/decode_issue_cases.txt", "r");
    num_cases = 0;
    if (fd == 0) begin
      $display("Could not open the cases file");
    end else begin
      while (!$feof(fd) && num_cases < MAX_CASES) begin
        n = $fgets(line, fd);
        // Skip comments and blank lines
        if (n > 8 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                      f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
          if (n == 10) begin
            cases[num_cases] = {f[0], f[1], f[2], f[3][7:0], f[4], f[5],
                                f[6][7:0], f[7][7:0], f[8][7:0], f[9]};
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------
  // Pipe ready and completions
  // ------------------------------
  always @(posedge clk) begin
    complete_t c;
    if (rst) begin
      ex_rdy    <= '0;
      complete  <= '0;
      issue_idx <= 0;
      cycle     <= 0;
    end else begin
      cycle <= cycle + 1;
      // Each pipe ready about three cycles in four
      ex_rdy <= {($random(seed) & 3) != 0, ($random(seed) & 3) != 0};
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        complete <= comp_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        complete <= '0;
      end
      if (|(ex_val & ex_rdy) && issue_idx < num_cases) begin
        c.val   = 1'b1;
        c.wen   = (cases[issue_idx].preg != 8'd0);
        c.preg  = PREG_BITS'(cases[issue_idx].preg);
        c.ppreg = PREG_BITS'(cases[issue_idx].ppreg);
        c.wdata = cases[issue_idx].wdata;
        c.seq   = SEQ_BITS'(issue_idx);
        comp_q.push_back(c);
        due_q.push_back(cycle + 2);
        issue_idx <= issue_idx + 1;
      end
    end
  end

  // ------------------------------
  // Fetch driver and end of run
  // ------------------------------
  initial begin
    int  cycles;
    bit  got;
    seed      = 27;
    fetch_val = 1'b0;
    fetch_pkt = '0;
    ex_rdy    = '0;
    complete  = '0;
    issue_idx = 0;
    load_cases();

    // Reset is sampled on clock edges only
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (rst && cycles < TIMEOUT);
    if (rst || num_cases == 0) begin
      $display("Reset never ended or no cases were loaded");
      $display("Testbench failed");
      $finish;
    end

    for (int i = 0; i < num_cases; i++) begin
      fetch_val <= 1'b1;
      fetch_pkt <= {cases[i].inst, cases[i].pc, SEQ_BITS'(i)};
      got    = 1'b0;
      cycles = 0;
      while (!got && cycles < TIMEOUT) begin
        @(posedge clk);
        got = fetch_rdy;
        cycles++;
      end
      if (!got) begin
        $display("Timeout: case %0d was never accepted by the fetch register", i);
        $display("Testbench failed");
        $finish;
      end
    end
    fetch_val <= 1'b0;

    cycles = 0;
    while (tests_done < num_cases && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (tests_done < num_cases) begin
      $display("Timeout: only %0d of %0d instructions issued", tests_done, num_cases);
      $display("Testbench failed");
      $finish;
    end
    // Let the last completions and any stray issue show up
    repeat (6) @(posedge clk);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d protocol errors",
             tests_done, tests_done - tests_failed, tests_failed, proto_errs);
    if (tests_failed == 0 && proto_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
